// File: verilog/pcie_dll_pkg.sv
`default_nettype none

package pcie_dll_pkg;

  typedef logic [11:0] seq_num_t;
  typedef logic [7:0]  fc_hdr_t;
  typedef logic [11:0] fc_data_t;
  typedef logic [15:0] crc16_t;
  typedef logic [31:0] dllp_word_t;

  // dllp crc generator
  localparam crc16_t CRC16_POLY = 16'h100B;
  localparam crc16_t CRC16_INIT = 16'hFFFF;

  // type codes with the vc field at zero
  typedef enum logic [7:0] {
    DLLP_ACK         = 8'h00,
    DLLP_NAK         = 8'h10,
    DLLP_INITFC1_P   = 8'h40,
    DLLP_INITFC1_NP  = 8'h50,
    DLLP_INITFC1_CPL = 8'h60,
    DLLP_UPDATEFC_P  = 8'h80,
    DLLP_UPDATEFC_NP = 8'h90,
    DLLP_UPDATEFC_CPL = 8'hA0,
    DLLP_INITFC2_P   = 8'hC0,
    DLLP_INITFC2_NP  = 8'hD0,
    DLLP_INITFC2_CPL = 8'hE0
  } dllp_type_e;

  typedef struct packed {
    logic     valid;
    logic     is_ack;
    seq_num_t seq;
  } ack_nak_t;

  // credits granted by the link partner
  typedef struct packed {
    fc_hdr_t  ph;
    fc_data_t pd;
    fc_hdr_t  nph;
    fc_data_t npd;
  } fc_credits_t;

  // byte 0 sits in bits 31:24, byte 3 in bits 7:0
  function automatic logic [7:0] get_byte(dllp_word_t w, int unsigned idx);
    return w[31 - 8 * idx -: 8];
  endfunction

  function automatic seq_num_t get_ack_seq(dllp_word_t w);
    logic [7:0] b2;
    logic [7:0] b3;
    b2 = get_byte(w, 2);
    b3 = get_byte(w, 3);
    return {b2[3:0], b3};
  endfunction

  function automatic fc_hdr_t get_fc_hdr(dllp_word_t w);
    logic [7:0] b1;
    logic [7:0] b2;
    b1 = get_byte(w, 1);
    b2 = get_byte(w, 2);
    return {b1[5:0], b2[7:6]};
  endfunction

  function automatic fc_data_t get_fc_data(dllp_word_t w);
    logic [7:0] b2;
    logic [7:0] b3;
    b2 = get_byte(w, 2);
    b3 = get_byte(w, 3);
    return {b2[3:0], b3};
  endfunction

endpackage

`default_nettype wire

// File: verilog/dllp_crc16.sv
`default_nettype none

module dllp_crc16 (
  input  pcie_dll_pkg::dllp_word_t data_i,
  output pcie_dll_pkg::crc16_t     crc_o
);

  import pcie_dll_pkg::*;

  crc16_t crc_c;

  // bytes 0..3 in order, each one lsb first
  always_comb begin
    logic [7:0] cur_byte;
    logic       fb;
    crc_c = CRC16_INIT;
    cur_byte = '0;
    fb = 1'b0;
    for (int b = 0; b < 4; b++) begin
      cur_byte = data_i[31 - 8 * b -: 8];
      for (int i = 0; i < 8; i++) begin
        fb = crc_c[15] ^ cur_byte[i];
        crc_c = {crc_c[14:0], 1'b0};
        if (fb) begin
          crc_c = crc_c ^ CRC16_POLY;
        end
      end
    end
  end

  // final value goes out inverted
  assign crc_o = ~crc_c;

endmodule

`default_nettype wire

// File: verilog/dllp_rx_handler.sv
`default_nettype none

module dllp_rx_handler (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      phy_link_up_i,
  input  pcie_dll_pkg::dllp_word_t  s_dllp_data_i,
  input  logic                      s_dllp_valid_i,
  input  logic                      s_dllp_last_i,
  output logic                      s_dllp_ready_o,
  output pcie_dll_pkg::ack_nak_t    ack_nak_o,
  output pcie_dll_pkg::fc_credits_t fc_credits_o,
  output logic                      fc1_done_o,
  output logic                      fc2_done_o,
  output logic                      dllp_crc_err_o
);

  import pcie_dll_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK,
    ST_PROCESS
  } rx_state_e;

  // class index for the seen flags
  localparam int CLS_P   = 0;
  localparam int CLS_NP  = 1;
  localparam int CLS_CPL = 2;

  rx_state_e state_r, state_c;

  dllp_word_t body_r;
  crc16_t     crc_calc;
  crc16_t     crc_r;
  dllp_type_e dllp_type;

  logic beat_fire;
  logic crc_err_c, crc_err_r;

  fc_credits_t credits_r, credits_c;
  logic [2:0]  fc1_seen_r, fc1_seen_c;
  logic [2:0]  fc2_seen_r, fc2_seen_c;
  ack_nak_t    ack_nak_c;

  dllp_crc16 crc_inst (
    .data_i(s_dllp_data_i),
    .crc_o (crc_calc)
  );

  assign beat_fire = s_dllp_valid_i & s_dllp_ready_o;
  assign dllp_type = dllp_type_e'(body_r[31:24]);

  // beat capture
  always_comb begin
    state_c = state_r;
    s_dllp_ready_o = 1'b0;
    crc_err_c = 1'b0;
    case (state_r)
      ST_IDLE: begin
        s_dllp_ready_o = phy_link_up_i;
        if (beat_fire) begin
          state_c = ST_CHECK;
        end
      end
      ST_CHECK: begin
        s_dllp_ready_o = 1'b1;
        if (!phy_link_up_i) begin
          state_c = ST_IDLE;
        end else if (beat_fire) begin
          if (s_dllp_last_i && (crc_r == s_dllp_data_i[15:0])) begin
            state_c = ST_PROCESS;
          end else begin
            state_c = ST_IDLE;
            crc_err_c = 1'b1;
          end
        end
      end
      ST_PROCESS: begin
        state_c = ST_IDLE;
      end
      default: begin
        state_c = ST_IDLE;
      end
    endcase
  end

  // decode of the stored body, only in PROCESS
  always_comb begin
    ack_nak_c = '0;
    credits_c = credits_r;
    fc1_seen_c = fc1_seen_r;
    fc2_seen_c = fc2_seen_r;
    if (state_r == ST_PROCESS) begin
      case (dllp_type)
        DLLP_ACK, DLLP_NAK: begin
          ack_nak_c.valid = 1'b1;
          ack_nak_c.is_ack = (dllp_type == DLLP_ACK);
          ack_nak_c.seq = get_ack_seq(body_r);
        end
        DLLP_INITFC1_P, DLLP_INITFC2_P, DLLP_UPDATEFC_P: begin
          credits_c.ph = get_fc_hdr(body_r);
          credits_c.pd = get_fc_data(body_r);
        end
        DLLP_INITFC1_NP, DLLP_INITFC2_NP, DLLP_UPDATEFC_NP: begin
          credits_c.nph = get_fc_hdr(body_r);
          credits_c.npd = get_fc_data(body_r);
        end
        default: begin
        end
      endcase
      // completion credits are infinite, only the flag matters
      case (dllp_type)
        DLLP_INITFC1_P:   fc1_seen_c[CLS_P] = 1'b1;
        DLLP_INITFC1_NP:  fc1_seen_c[CLS_NP] = 1'b1;
        DLLP_INITFC1_CPL: fc1_seen_c[CLS_CPL] = 1'b1;
        DLLP_INITFC2_P:   fc2_seen_c[CLS_P] = 1'b1;
        DLLP_INITFC2_NP:  fc2_seen_c[CLS_NP] = 1'b1;
        DLLP_INITFC2_CPL: fc2_seen_c[CLS_CPL] = 1'b1;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_r <= ST_IDLE;
      crc_err_r <= 1'b0;
      credits_r <= '0;
      fc1_seen_r <= '0;
      fc2_seen_r <= '0;
    end else begin
      state_r <= state_c;
      crc_err_r <= crc_err_c;
      credits_r <= credits_c;
      fc1_seen_r <= fc1_seen_c;
      fc2_seen_r <= fc2_seen_c;
    end
  end

  // body word and its crc, taken with the first beat
  always_ff @(posedge clk_i) begin
    if (state_r == ST_IDLE && beat_fire) begin
      body_r <= s_dllp_data_i;
      crc_r <= crc_calc;
    end
  end

  assign ack_nak_o = ack_nak_c;
  assign fc_credits_o = credits_r;
  assign fc1_done_o = &fc1_seen_r;
  assign fc2_done_o = &fc2_seen_r;
  assign dllp_crc_err_o = crc_err_r;

endmodule

`default_nettype wire

// File: verilog/ack_seq_tracker.sv
`default_nettype none

module ack_seq_tracker (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  pcie_dll_pkg::ack_nak_t ack_nak_i,
  input  pcie_dll_pkg::seq_num_t tx_next_seq_i,
  output pcie_dll_pkg::seq_num_t acked_seq_o,
  output logic                   replay_req_o,
  output logic                   seq_err_o
);

  import pcie_dll_pkg::*;

  seq_num_t acked_seq_r;
  seq_num_t rep_dist;
  seq_num_t out_dist;
  logic     in_window;
  logic     replay_r;
  logic     seq_err_r;

  // forward distances, modulo 4096 by the 12-bit width
  assign rep_dist = ack_nak_i.seq - acked_seq_r;
  assign out_dist = tx_next_seq_i - acked_seq_r;
  assign in_window = (rep_dist <= seq_num_t'(out_dist - 12'd1));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      acked_seq_r <= 12'hFFF;
      replay_r <= 1'b0;
      seq_err_r <= 1'b0;
    end else begin
      replay_r <= 1'b0;
      seq_err_r <= 1'b0;
      if (ack_nak_i.valid) begin
        if (in_window) begin
          acked_seq_r <= ack_nak_i.seq;
          // a nak also asks the transmitter to replay
          replay_r <= ~ack_nak_i.is_ack;
        end else begin
          seq_err_r <= 1'b1;
        end
      end
    end
  end

  assign acked_seq_o = acked_seq_r;
  assign replay_req_o = replay_r;
  assign seq_err_o = seq_err_r;

endmodule

`default_nettype wire

// File: verilog/dll_rx_top.sv
`default_nettype none

module dll_rx_top (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      phy_link_up_i,
  input  pcie_dll_pkg::dllp_word_t  s_dllp_data_i,
  input  logic                      s_dllp_valid_i,
  input  logic                      s_dllp_last_i,
  input  pcie_dll_pkg::seq_num_t    tx_next_seq_i,
  output logic                      s_dllp_ready_o,
  output pcie_dll_pkg::ack_nak_t    ack_nak_o,
  output pcie_dll_pkg::fc_credits_t fc_credits_o,
  output logic                      fc1_done_o,
  output logic                      fc2_done_o,
  output logic                      dllp_crc_err_o,
  output pcie_dll_pkg::seq_num_t    acked_seq_o,
  output logic                      replay_req_o,
  output logic                      seq_err_o
);

  dllp_rx_handler handler_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .phy_link_up_i (phy_link_up_i),
    .s_dllp_data_i (s_dllp_data_i),
    .s_dllp_valid_i(s_dllp_valid_i),
    .s_dllp_last_i (s_dllp_last_i),
    .s_dllp_ready_o(s_dllp_ready_o),
    .ack_nak_o     (ack_nak_o),
    .fc_credits_o  (fc_credits_o),
    .fc1_done_o    (fc1_done_o),
    .fc2_done_o    (fc2_done_o),
    .dllp_crc_err_o(dllp_crc_err_o)
  );

  // ack/nak reports feed the transmit-side sequence state
  ack_seq_tracker tracker_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ack_nak_i    (ack_nak_o),
    .tx_next_seq_i(tx_next_seq_i),
    .acked_seq_o  (acked_seq_o),
    .replay_req_o (replay_req_o),
    .seq_err_o    (seq_err_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_dllp_util.svh
`ifndef TB_DLLP_UTIL_SVH
`define TB_DLLP_UTIL_SVH

// poly 100Bh, start all ones, bytes 0..3 lsb first, inverted at the end
function automatic logic [15:0] crc16_model(input logic [31:0] w);
  logic [15:0] c;
  logic [7:0]  b;
  logic        fb;
  c = 16'hFFFF;
  for (int k = 0; k < 4; k++) begin
    b = w[31 - 8 * k -: 8];
    for (int i = 0; i < 8; i++) begin
      fb = c[15] ^ b[i];
      c = {c[14:0], 1'b0} ^ (fb ? 16'h100B : 16'h0000);
    end
  end
  return ~c;
endfunction

function automatic logic [31:0] make_ack_word(input logic is_ack, input logic [11:0] seq);
  return {(is_ack ? 8'h00 : 8'h10), 8'h00, 4'h0, seq[11:8], seq[7:0]};
endfunction

// hdr splits over byte 1 and the top of byte 2
function automatic logic [31:0] make_fc_word(input logic [7:0] code, input logic [7:0] hdr,
                                             input logic [11:0] data);
  return {code, 2'b00, hdr[7:2], hdr[1:0], 2'b00, data[11:8], data[7:0]};
endfunction

// returns on the falling edge before the accepting rising edge
task automatic wait_ready();
  int n;
  n = 0;
  @(negedge clk_i);
  while (!s_dllp_ready_o) begin
    n++;
    if (n > 50) begin
      $display("timeout: ready stayed low for 50 cycles at t=%0t", $time);
      err_cnt++;
      finish_run();
    end
    @(negedge clk_i);
  end
endtask

task automatic send_dllp(input logic [31:0] body, input logic corrupt, input logic last_flag,
                         input logic keep_valid);
  logic [15:0] crc;
  crc = crc16_model(body) ^ (corrupt ? 16'h0001 : 16'h0000);
  s_dllp_data_i = body;
  s_dllp_valid_i = 1'b1;
  s_dllp_last_i = 1'b0;
  wait_ready();
  @(posedge clk_i);
  #2;
  s_dllp_data_i = {16'h0000, crc};
  s_dllp_last_i = last_flag;
  wait_ready();
  pend_body = body;
  pend_good = last_flag && (crc == crc16_model(body));
  pend_valid = 1'b1;
  @(posedge clk_i);
  #2;
  pend_valid = 1'b0;
  if (!keep_valid) begin
    s_dllp_valid_i = 1'b0;
    s_dllp_last_i = 1'b0;
  end
endtask

`endif

// File: sim/tb_dll_rx_top.sv
`default_nettype none

module tb_dll_rx_top;

  import pcie_dll_pkg::*;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        phy_link_up_i;
  dllp_word_t  s_dllp_data_i;
  logic        s_dllp_valid_i;
  logic        s_dllp_last_i;
  seq_num_t    tx_next_seq_i;
  logic        s_dllp_ready_o;
  ack_nak_t    ack_nak_o;
  fc_credits_t fc_credits_o;
  logic        fc1_done_o;
  logic        fc2_done_o;
  logic        dllp_crc_err_o;
  seq_num_t    acked_seq_o;
  logic        replay_req_o;
  logic        seq_err_o;

  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int test_err_base = 0;

  // expected-value pipeline fed by the send task
  logic        pend_valid = 1'b0;
  logic        pend_good = 1'b0;
  logic [31:0] pend_body = '0;
  logic        s1_good;
  logic [31:0] s1_body;
  ack_nak_t    exp_ack;
  logic        exp_err;
  fc_credits_t exp_credits;
  logic [2:0]  exp_fc1;
  logic [2:0]  exp_fc2;
  seq_num_t    exp_acked;
  logic        exp_replay;
  logic        exp_seqerr;

  dll_rx_top dut0 (.*);

  always #10 clk_i = ~clk_i;

  task automatic finish_run();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  `include "tb_dllp_util.svh"

  task automatic report_fail(input string name, input logic [63:0] e, input logic [63:0] a);
    err_cnt++;
    $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, e, a);
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (5) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
  endtask

  always @(posedge clk_i or posedge rst_i) begin
    seq_num_t rep;
    seq_num_t win;
    if (rst_i) begin
      s1_good <= 1'b0;
      s1_body <= '0;
      exp_ack <= '0;
      exp_err <= 1'b0;
      exp_credits <= '0;
      exp_fc1 <= '0;
      exp_fc2 <= '0;
      exp_acked <= 12'hFFF;
      exp_replay <= 1'b0;
      exp_seqerr <= 1'b0;
    end else begin
      exp_ack <= '0;
      exp_err <= pend_valid && !pend_good;
      s1_good <= pend_valid && pend_good;
      s1_body <= pend_body;
      if (pend_valid && pend_good && (pend_body[31:24] == 8'h00 || pend_body[31:24] == 8'h10))
        exp_ack <= {1'b1, pend_body[31:24] == 8'h00, pend_body[11:0]};
      if (s1_good) begin
        case (s1_body[31:24])
          8'h40, 8'hC0, 8'h80: exp_credits[39:20] <= {s1_body[21:14], s1_body[11:0]};
          8'h50, 8'hD0, 8'h90: exp_credits[19:0] <= {s1_body[21:14], s1_body[11:0]};
          default: ;
        endcase
        case (s1_body[31:24])
          8'h40: exp_fc1[0] <= 1'b1;
          8'h50: exp_fc1[1] <= 1'b1;
          8'h60: exp_fc1[2] <= 1'b1;
          8'hC0: exp_fc2[0] <= 1'b1;
          8'hD0: exp_fc2[1] <= 1'b1;
          8'hE0: exp_fc2[2] <= 1'b1;
          default: ;
        endcase
      end
      // window rule on forward distances
      rep = exp_ack.seq - exp_acked;
      win = tx_next_seq_i - exp_acked - 12'd1;
      exp_replay <= exp_ack.valid && !exp_ack.is_ack && (rep <= win);
      exp_seqerr <= exp_ack.valid && (rep > win);
      if (exp_ack.valid && rep <= win)
        exp_acked <= exp_ack.seq;
    end
  end

  always @(negedge clk_i) begin
    if (!rst_i) begin
      check_cnt++;
      assert (phy_link_up_i || !s_dllp_ready_o) else report_fail("s_dllp_ready_o", 0, 1);
      assert (!(s1_good && s_dllp_ready_o)) else report_fail("s_dllp_ready_o", 0, 1);
      assert (ack_nak_o == exp_ack) else report_fail("ack_nak_o", exp_ack, ack_nak_o);
      assert (dllp_crc_err_o == exp_err)
        else report_fail("dllp_crc_err_o", exp_err, dllp_crc_err_o);
      assert (fc_credits_o == exp_credits)
        else report_fail("fc_credits_o", exp_credits, fc_credits_o);
      assert (fc1_done_o == &exp_fc1) else report_fail("fc1_done_o", &exp_fc1, fc1_done_o);
      assert (fc2_done_o == &exp_fc2) else report_fail("fc2_done_o", &exp_fc2, fc2_done_o);
      assert (acked_seq_o == exp_acked) else report_fail("acked_seq_o", exp_acked, acked_seq_o);
      assert (replay_req_o == exp_replay)
        else report_fail("replay_req_o", exp_replay, replay_req_o);
      assert (seq_err_o == exp_seqerr) else report_fail("seq_err_o", exp_seqerr, seq_err_o);
    end
  end

  initial begin
    logic [7:0] codes [6];
    logic [7:0] code;
    codes = '{8'h00, 8'h10, 8'h40, 8'h50, 8'h80, 8'h90};
    void'($urandom(73));
    phy_link_up_i = 1'b0;
    s_dllp_data_i = '0;
    s_dllp_valid_i = 1'b0;
    s_dllp_last_i = 1'b0;
    tx_next_seq_i = 12'd20;
    apply_reset();
    repeat (4) @(posedge clk_i);
    #2;
    phy_link_up_i = 1'b1;
    end_test("reset and link down");

    for (int i = 0; i < 6; i++) begin
      tx_next_seq_i = seq_num_t'($urandom);
      send_dllp(make_ack_word(i[0], seq_num_t'($urandom)), 1'b0, 1'b1, 1'b0);
    end
    end_test("ack and nak decode");

    send_dllp(make_fc_word(8'h40, 8'($urandom), 12'($urandom)), 1'b1, 1'b1, 1'b0);
    send_dllp(make_ack_word(1'b1, 12'($urandom)), 1'b0, 1'b0, 1'b0);
    send_dllp(make_ack_word(1'b0, 12'($urandom)), 1'b0, 1'b1, 1'b0);
    end_test("crc errors");

    send_dllp(make_fc_word(8'h40, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, 1'b0);
    send_dllp(make_fc_word(8'h50, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, 1'b0);
    send_dllp(make_fc_word(8'h60, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, 1'b0);
    send_dllp(make_fc_word(8'hC0, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, 1'b0);
    send_dllp(make_fc_word(8'hD0, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, 1'b0);
    send_dllp(make_fc_word(8'hE0, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, 1'b0);
    send_dllp(make_fc_word(8'h90, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, 1'b0);
    // vc 1 and a pm dllp
    send_dllp(make_fc_word(8'h41, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, 1'b0);
    send_dllp(32'h2000_0000, 1'b0, 1'b1, 1'b0);
    end_test("flow control init");

    apply_reset();
    tx_next_seq_i = 12'd20;
    send_dllp(make_ack_word(1'b1, 12'd5), 1'b0, 1'b1, 1'b0);
    send_dllp(make_ack_word(1'b0, 12'd9), 1'b0, 1'b1, 1'b0);
    send_dllp(make_ack_word(1'b1, 12'd30), 1'b0, 1'b1, 1'b0);
    // tracker takes the report on the edge that ends PROCESS
    @(posedge clk_i);
    #2;
    tx_next_seq_i = 12'd4091;
    send_dllp(make_ack_word(1'b1, 12'd4090), 1'b0, 1'b1, 1'b0);
    @(posedge clk_i);
    #2;
    tx_next_seq_i = 12'd3;
    send_dllp(make_ack_word(1'b1, 12'd1), 1'b0, 1'b1, 1'b0);
    end_test("ack tracking");

    for (int i = 0; i < 8; i++) begin
      code = codes[$urandom % 6];
      send_dllp(make_fc_word(code, 8'($urandom), 12'($urandom)), 1'b0, 1'b1, i < 7);
    end
    repeat (3) @(posedge clk_i);
    end_test("back to back");
    finish_run();
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
verilog/pcie_dll_pkg.sv
verilog/dllp_crc16.sv
verilog/dllp_rx_handler.sv
verilog/ack_seq_tracker.sv
verilog/dll_rx_top.sv
sim/tb_dll_rx_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module tb_dll_rx_top \
  -f sources.f \
  -Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
